//--- bayer_demosaic.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_settings.svh"

module bayer_demosaic #(
  parameter int line_depth = `CAM_LINE_DEPTH
) (
  input  wire                       ccd_pixel_clk,
  input  wire                       hps_fpga_reset_n,
  input  wire pixel_pkg::raw_t      sample,
  input  wire                       sample_valid,
  input  wire capture_pkg::coord_t  column,
  input  wire capture_pkg::coord_t  row,
  output pixel_pkg::comp_t          red,
  output pixel_pkg::comp_t          green,
  output pixel_pkg::comp_t          blue,
  output logic                      rgb_valid
);

  localparam int addr_width = $clog2(line_depth);

  // One even row, green-red order
  pixel_pkg::raw_t line_buf [line_depth];

  logic [addr_width-1:0] addr;
  pixel_pkg::raw_t       line_rd;
  // Buffered even sample one column back
  pixel_pkg::raw_t       prev_buf;
  // Odd-row sample one column back, the blue site
  pixel_pkg::raw_t       prev_odd;
  // Two greens, one guard bit
  logic [`CAM_RAW_WIDTH:0] green_sum;
  logic                  odd_row;
  logic                  odd_col;

  // ==================================================
  // Line buffer
  // ==================================================
  assign addr    = column[addr_width-1:0];
  assign line_rd = line_buf[addr];
  assign odd_row = row[0];
  assign odd_col = column[0];

  // Even rows fill the buffer at their column
  always_ff @(posedge ccd_pixel_clk) begin
    if (sample_valid && !odd_row) begin
      line_buf[addr] <= sample;
    end
  end

  // ==================================================
  // 2x2 block reconstruction
  // ==================================================
  // Green averages the even-row green and the odd-row green
  assign green_sum = {1'b0, prev_buf} + {1'b0, sample};

  always_ff @(posedge ccd_pixel_clk) begin
    if (sample_valid && odd_row) begin
      prev_buf <= line_rd;
      prev_odd <= sample;
      // Block is complete at the odd column
      if (odd_col) begin
        red   <= line_rd;
        green <= green_sum[`CAM_RAW_WIDTH:1];
        blue  <= prev_odd;
      end
    end
  end

  // One pixel per block, one cycle after its last sample
  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      rgb_valid <= 1'b0;
    end else begin
      rgb_valid <= sample_valid & odd_row & odd_col;
    end
  end

endmodule

`default_nettype wire

//--- cam_settings.svh
`ifndef CAM_SETTINGS_SVH
`define CAM_SETTINGS_SVH

// ==================================================
// Camera pixel path widths and depths
// ==================================================

// Raw Bayer sample from the sensor
`define CAM_RAW_WIDTH 12

// Column and row counters
`define CAM_COORD_WIDTH 12

// Columns held by the demosaic line buffer
`define CAM_LINE_DEPTH 1280

// Hue circle, 0 to 255
`define CAM_HUE_WIDTH 8

// Packed output word
`define CAM_WORD_WIDTH 16

// Bits kept per component in RGB mode
`define CAM_RGB_BITS 5

`endif

//--- camera_capture.sv
`timescale 1ns/10ps
`default_nettype none

module camera_capture (
  input  wire                       ccd_pixel_clk,
  input  wire                       hps_fpga_reset_n,
  input  wire pixel_pkg::raw_t      raw,
  input  wire                       frame_valid,
  input  wire                       line_valid,
  input  wire                       capture_start,
  output pixel_pkg::raw_t           sample,
  output logic                      sample_valid,
  output capture_pkg::coord_t       column,
  output capture_pkg::coord_t       row,
  output capture_pkg::frame_count_t frame_count
);

  // Previous frame and line valid for edges
  logic fval_d;
  logic lval_d;
  // Set for the whole of an accepted frame
  logic armed;
  // Next column and current row indices
  capture_pkg::coord_t col_cnt;
  capture_pkg::coord_t row_cnt;

  logic fval_rise;
  logic fval_fall;
  logic lval_fall;
  logic active;
  logic take;

  // ==================================================
  // Edge detection and sample gating
  // ==================================================
  assign fval_rise = frame_valid & ~fval_d;
  assign fval_fall = ~frame_valid & fval_d;
  assign lval_fall = ~line_valid & lval_d;

  // Arm on the frame start itself, start level sampled only here
  assign active = armed | (fval_rise & capture_start);
  assign take   = active & frame_valid & line_valid;

  // ==================================================
  // Control state and counters
  // ==================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      fval_d       <= 1'b0;
      lval_d       <= 1'b0;
      armed        <= 1'b0;
      sample_valid <= 1'b0;
      col_cnt      <= '0;
      row_cnt      <= '0;
      frame_count  <= '0;
    end else begin
      fval_d       <= frame_valid;
      lval_d       <= line_valid;
      sample_valid <= take;

      // Frame end closes an armed frame
      if (fval_fall) begin
        armed <= 1'b0;
        if (armed) begin
          frame_count <= frame_count + 1'b1;
        end
      end else if (fval_rise && capture_start) begin
        armed <= 1'b1;
      end

      // Column restarts after every line
      if (lval_fall) begin
        col_cnt <= '0;
      end else if (take) begin
        col_cnt <= col_cnt + 1'b1;
      end

      // Row steps only after lines that carried samples
      if (fval_rise) begin
        row_cnt <= '0;
      end else if (lval_fall && col_cnt != '0) begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  // Sample and its coordinates
  always_ff @(posedge ccd_pixel_clk) begin
    if (take) begin
      sample <= raw;
      column <= col_cnt;
      row    <= fval_rise ? '0 : row_cnt;
    end
  end

endmodule

`default_nettype wire

//--- capture_pkg.sv
`default_nettype none

`include "cam_settings.svh"

// ==================================================
// Frame geometry and frame counting
// ==================================================
package capture_pkg;

  // Column or row index inside a frame
  typedef logic [`CAM_COORD_WIDTH-1:0] coord_t;

  // Captured frames since reset
  typedef logic [31:0] frame_count_t;

endpackage

`default_nettype wire

//--- hue_calc.sv
`timescale 1ns/10ps
`default_nettype none

module hue_calc (
  input  wire                    ccd_pixel_clk,
  input  wire                    hps_fpga_reset_n,
  input  wire pixel_pkg::comp8_t red,
  input  wire pixel_pkg::comp8_t green,
  input  wire pixel_pkg::comp8_t blue,
  input  wire                    in_valid,
  output pixel_pkg::hue_t        hue,
  output logic                   hue_valid
);

  // Sector of the largest component
  localparam logic [1:0] sec_red   = 2'd0;
  localparam logic [1:0] sec_green = 2'd1;
  localparam logic [1:0] sec_blue  = 2'd2;

  // Stage one, combinational
  pixel_pkg::comp8_t  c_max;
  pixel_pkg::comp8_t  c_min;
  logic [1:0]         c_sector;
  logic signed [8:0]  c_num;
  // Stage one registers
  logic               s1_valid;
  logic [7:0]         s1_diff;
  logic [1:0]         s1_sector;
  logic signed [8:0]  s1_num;
  // Stage two, combinational
  logic signed [15:0] c_prod;
  logic signed [15:0] c_div;
  logic signed [15:0] c_quot;
  // Stage two registers
  logic               s2_valid;
  logic [1:0]         s2_sector;
  logic [7:0]         s2_quot;
  // Stage three offset
  pixel_pkg::hue_t    c_offset;

  // ==================================================
  // Stage one: extremes, sector, numerator
  // ==================================================
  always_comb begin
    // Red wins ties, then green
    if (red >= green && red >= blue) begin
      c_sector = sec_red;
      c_max    = red;
      c_num    = $signed({1'b0, green}) - $signed({1'b0, blue});
    end else if (green >= blue) begin
      c_sector = sec_green;
      c_max    = green;
      c_num    = $signed({1'b0, blue}) - $signed({1'b0, red});
    end else begin
      c_sector = sec_blue;
      c_max    = blue;
      c_num    = $signed({1'b0, red}) - $signed({1'b0, green});
    end
    c_min = (red <= green) ? red : green;
    if (blue < c_min) begin
      c_min = blue;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    s1_diff   <= c_max - c_min;
    s1_sector <= c_sector;
    s1_num    <= c_num;
  end

  // ==================================================
  // Stage two: 43 * num / diff, toward zero
  // ==================================================
  assign c_prod = s1_num * 16'sd43;
  assign c_div  = $signed({8'd0, s1_diff});
  // Grey pixel, no division, quotient zero
  assign c_quot = (s1_diff == 8'd0) ? 16'sd0 : c_prod / c_div;

  always_ff @(posedge ccd_pixel_clk) begin
    s2_sector <= s1_sector;
    s2_quot   <= c_quot[7:0];
  end

  // ==================================================
  // Stage three: sector offset, modulo 256
  // ==================================================
  always_comb begin
    case (s2_sector)
      sec_green: c_offset = 8'd85;
      sec_blue:  c_offset = 8'd171;
      default:   c_offset = 8'd0;
    endcase
  end

  always_ff @(posedge ccd_pixel_clk) begin
    hue <= c_offset + s2_quot;
  end

  // Valid travels alongside the three stages
  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      hue_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      s2_valid  <= s1_valid;
      hue_valid <= s2_valid;
    end
  end

endmodule

`default_nettype wire

//--- pixel_path_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_settings.svh"

module pixel_path_top #(
  parameter int line_depth = `CAM_LINE_DEPTH
) (
  input  wire                       ccd_pixel_clk,
  input  wire                       hps_fpga_reset_n,
  input  wire pixel_pkg::raw_t      ccd_data,
  input  wire                       ccd_fval,
  input  wire                       ccd_lval,
  input  wire                       capture_start,
  input  wire                       hue_mode,
  output pixel_pkg::pixel_word_u    word,
  output logic                      word_valid,
  output capture_pkg::frame_count_t frame_count
);

  // Camera pins after one register
  pixel_pkg::raw_t     ccd_data_q;
  logic                ccd_fval_q;
  logic                ccd_lval_q;
  // Capture to demosaic
  pixel_pkg::raw_t     sample;
  logic                sample_valid;
  capture_pkg::coord_t column;
  capture_pkg::coord_t row;
  // Demosaic to hue and packer
  pixel_pkg::comp_t    red;
  pixel_pkg::comp_t    green;
  pixel_pkg::comp_t    blue;
  logic                rgb_valid;
  // Hue to packer
  pixel_pkg::hue_t     hue;
  logic                hue_valid;

  // ==================================================
  // Pin register
  // ==================================================
  always_ff @(posedge ccd_pixel_clk) begin
    ccd_data_q <= ccd_data;
    if (!hps_fpga_reset_n) begin
      ccd_fval_q <= 1'b0;
      ccd_lval_q <= 1'b0;
    end else begin
      ccd_fval_q <= ccd_fval;
      ccd_lval_q <= ccd_lval;
    end
  end

  camera_capture camera_capture_i (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .raw              (ccd_data_q),
    .frame_valid      (ccd_fval_q),
    .line_valid       (ccd_lval_q),
    .capture_start    (capture_start),
    .sample           (sample),
    .sample_valid     (sample_valid),
    .column           (column),
    .row              (row),
    .frame_count      (frame_count)
  );

  bayer_demosaic #(
    .line_depth (line_depth)
  ) bayer_demosaic_i (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .sample           (sample),
    .sample_valid     (sample_valid),
    .column           (column),
    .row              (row),
    .red              (red),
    .green            (green),
    .blue             (blue),
    .rgb_valid        (rgb_valid)
  );

  // Hue sees the top byte of each component
  hue_calc hue_calc_i (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .red              (red[`CAM_RAW_WIDTH-1 -: $bits(pixel_pkg::comp8_t)]),
    .green            (green[`CAM_RAW_WIDTH-1 -: $bits(pixel_pkg::comp8_t)]),
    .blue             (blue[`CAM_RAW_WIDTH-1 -: $bits(pixel_pkg::comp8_t)]),
    .in_valid         (rgb_valid),
    .hue              (hue),
    .hue_valid        (hue_valid)
  );

  // ==================================================
  // Output packer
  // ==================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (hue_mode) begin
      word.hue.zero <= '0;
      word.hue.hue  <= hue;
    end else begin
      // 5:5:5 from the component MSBs
      word.rgb.zero  <= '0;
      word.rgb.red   <= red[`CAM_RAW_WIDTH-1 -: `CAM_RGB_BITS];
      word.rgb.green <= green[`CAM_RAW_WIDTH-1 -: `CAM_RGB_BITS];
      word.rgb.blue  <= blue[`CAM_RAW_WIDTH-1 -: `CAM_RGB_BITS];
    end
  end

  // Strobe follows whichever view is selected
  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= hue_mode ? hue_valid : rgb_valid;
    end
  end

endmodule

`default_nettype wire

//--- pixel_pkg.sv
`default_nettype none

`include "cam_settings.svh"

// ==================================================
// Pixel samples, components and output word
// ==================================================
package pixel_pkg;

  // One raw Bayer sample
  typedef logic [`CAM_RAW_WIDTH-1:0] raw_t;
  // Full precision color component
  typedef logic [`CAM_RAW_WIDTH-1:0] comp_t;
  // Reduced component, top eight bits, for hue
  typedef logic [7:0] comp8_t;
  // Hue on a 0 to 255 circle
  typedef logic [`CAM_HUE_WIDTH-1:0] hue_t;

  // RGB view, one zero bit then 5:5:5
  typedef struct packed {
    logic [`CAM_WORD_WIDTH-3*`CAM_RGB_BITS-1:0] zero;
    logic [`CAM_RGB_BITS-1:0] red;
    logic [`CAM_RGB_BITS-1:0] green;
    logic [`CAM_RGB_BITS-1:0] blue;
  } rgb_view_t;

  // Hue view, zero high byte then hue
  typedef struct packed {
    logic [`CAM_WORD_WIDTH-`CAM_HUE_WIDTH-1:0] zero;
    hue_t hue;
  } hue_view_t;

  // Same 16-bit word read two ways, selected by mode
  typedef union packed {
    rgb_view_t rgb;
    hue_view_t hue;
  } pixel_word_u;

endpackage

`default_nettype wire

//--- tb_pixel_path.sv
`timescale 1ns/10ps
`default_nettype none

`include "cam_settings.svh"

module tb_pixel_path;

  localparam int num_frames  = 9;
  localparam int half_period = 50;
  localparam int drive_delay = 10;
  localparam logic [31:0] base_seed = 32'h28ec_a746;

  // One table row describes a whole frame
  typedef struct packed {
    logic        start;
    logic        start_mid;
    logic        hue;
    int          lines;
    int          cols;
    int          blank;
    logic [11:0] mask;
    logic [31:0] seed;
  } frame_t;

  logic                      ccd_pixel_clk;
  logic                      hps_fpga_reset_n;
  pixel_pkg::raw_t           ccd_data;
  logic                      ccd_fval;
  logic                      ccd_lval;
  logic                      capture_start;
  logic                      hue_mode;
  pixel_pkg::pixel_word_u    word;
  logic                      word_valid;
  capture_pkg::frame_count_t frame_count;

  frame_t          frames [num_frames];
  // Current frame samples for up to 4 lines of 8
  pixel_pkg::raw_t px [4][8];
  logic [15:0]     expected_words [$];
  logic [15:0]     want;
  integer          seed;
  int              errors;
  int              words_seen;
  int              armed_frames;
  int              cycles;
  int              limit;

  pixel_path_top #(
    .line_depth (16)
  ) pixel_path_top_i (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .ccd_data         (ccd_data),
    .ccd_fval         (ccd_fval),
    .ccd_lval         (ccd_lval),
    .capture_start    (capture_start),
    .hue_mode         (hue_mode),
    .word             (word),
    .word_valid       (word_valid),
    .frame_count      (frame_count)
  );

  initial begin
    ccd_pixel_clk = 1'b0;
    forever #half_period ccd_pixel_clk = ~ccd_pixel_clk;
  end

  // ==================================================
  // Stimulus table and reference model
  // ==================================================
  function automatic frame_t entry(input logic start, input logic start_mid,
                                   input logic hue, input int lines, input int cols,
                                   input int blank, input logic [11:0] mask,
                                   input logic [31:0] seed_in);
    frame_t f;
    f.start     = start;
    f.start_mid = start_mid;
    f.hue       = hue;
    f.lines     = lines;
    f.cols      = cols;
    f.blank     = blank;
    f.mask      = mask;
    f.seed      = seed_in;
    return f;
  endfunction

  // Unarmed frame first, then RGB and hue frames with coarse masks for greys and ties
  task automatic load_table();
    frames[0] = entry(1'b0, 1'b0, 1'b0, 2, 4, 3, 12'hfff, 32'h0000_0011);
    frames[1] = entry(1'b1, 1'b0, 1'b0, 2, 8, 4, 12'hfff, 32'h0000_0022);
    frames[2] = entry(1'b1, 1'b0, 1'b1, 4, 8, 3, 12'hfff, 32'h0000_0033);
    frames[3] = entry(1'b1, 1'b0, 1'b1, 4, 6, 5, 12'h800, 32'h0000_0044);
    // Start raised after the first line leaves the frame unarmed
    frames[4] = entry(1'b0, 1'b1, 1'b1, 2, 4, 2, 12'hfff, 32'h0000_0055);
    frames[5] = entry(1'b1, 1'b0, 1'b0, 4, 8, 2, 12'hfff, 32'h0000_0066);
    frames[6] = entry(1'b1, 1'b0, 1'b1, 2, 8, 6, 12'hc00, 32'h0000_0077);
    frames[7] = entry(1'b1, 1'b0, 1'b0, 4, 2, 1, 12'hfff, 32'h0000_0088);
    // All samples zero so every block is grey
    frames[8] = entry(1'b1, 1'b0, 1'b1, 2, 4, 2, 12'h000, 32'h0000_0099);
  endtask

  // Lines with their blanking plus the trailing blank and frame end gap
  function automatic int frame_cycles(input frame_t f);
    return f.lines * (f.blank + f.cols) + 2 * f.blank + 9;
  endfunction

  // Hue on a 0 to 255 circle with sector offsets 0, 85 and 171
  function automatic logic [7:0] expected_hue(input int r, input int g, input int b);
    int mx;
    int mn;
    int num;
    int off;
    if (r >= g && r >= b) begin
      mx  = r;
      num = g - b;
      off = 0;
    end else if (g >= b) begin
      mx  = g;
      num = b - r;
      off = 85;
    end else begin
      mx  = b;
      num = r - g;
      off = 171;
    end
    mn = (r < g) ? r : g;
    mn = (b < mn) ? b : mn;
    // Grey
    if (mx == mn) begin
      return 8'd0;
    end
    return (off + (43 * num) / (mx - mn)) & 255;
  endfunction

  task automatic fill_samples(input frame_t f);
    logic [31:0] rnd;
    seed = base_seed ^ f.seed;
    for (int y = 0; y < f.lines; y++) begin
      for (int x = 0; x < f.cols; x++) begin
        rnd      = $random(seed);
        px[y][x] = rnd[11:0] & f.mask;
      end
    end
  endtask

  // One word per GR over BG block in raster order
  task automatic build_expected(input frame_t f);
    pixel_pkg::raw_t r;
    pixel_pkg::raw_t g;
    pixel_pkg::raw_t b;
    logic [12:0]     sum;
    for (int y = 1; y < f.lines; y += 2) begin
      for (int x = 1; x < f.cols; x += 2) begin
        r   = px[y-1][x];
        sum = {1'b0, px[y-1][x-1]} + {1'b0, px[y][x]};
        g   = sum[12:1];
        b   = px[y][x-1];
        if (f.hue) begin
          expected_words.push_back({8'h00, expected_hue(r[11:4], g[11:4], b[11:4])});
        end else begin
          expected_words.push_back({1'b0, r[11:7], g[11:7], b[11:7]});
        end
      end
    end
  endtask

  // ==================================================
  // Pin driving
  // ==================================================
  task automatic step(input logic fval, input logic lval, input pixel_pkg::raw_t data);
    @(posedge ccd_pixel_clk);
    #drive_delay;
    ccd_fval = fval;
    ccd_lval = lval;
    ccd_data = data;
  endtask

  task automatic run_frame(input frame_t f);
    logic [31:0] junk;
    fill_samples(f);
    if (f.start) begin
      build_expected(f);
    end
    // Levels only move between frames
    capture_start = f.start;
    hue_mode      = f.hue;
    for (int y = 0; y < f.lines; y++) begin
      // Horizontal blanking carries garbage data
      for (int i = 0; i < f.blank; i++) begin
        junk = $random(seed);
        step(1'b1, 1'b0, junk[11:0]);
      end
      for (int x = 0; x < f.cols; x++) begin
        step(1'b1, 1'b1, px[y][x]);
      end
      if (y == 0 && f.start_mid) begin
        capture_start = 1'b1;
      end
    end
    for (int i = 0; i < f.blank; i++) begin
      junk = $random(seed);
      step(1'b1, 1'b0, junk[11:0]);
    end
    // Frame end then pipeline drain
    for (int i = 0; i < f.blank + 9; i++) begin
      step(1'b0, 1'b0, '0);
    end
    if (f.start) begin
      armed_frames++;
    end
    assert (frame_count === armed_frames) else begin
      errors++;
      $display("FAIL frame_count: expected %h, got %h", armed_frames, frame_count);
    end
  endtask

  // ==================================================
  // Output monitor
  // ==================================================
  always @(negedge ccd_pixel_clk) begin
    if (hps_fpga_reset_n && word_valid) begin
      assert (expected_words.size() != 0) else begin
        errors++;
        $display("Word %h arrived while no word was expected", word);
      end
      if (expected_words.size() != 0) begin
        want = expected_words.pop_front();
        words_seen++;
        assert (word === want) else begin
          errors++;
          $display("FAIL word: expected %h, got %h", want, word);
        end
      end
    end
  end

  // Watchdog counting from reset release
  initial begin
    cycles = 0;
    @(posedge hps_fpga_reset_n);
    while (cycles < limit) begin
      @(posedge ccd_pixel_clk);
      cycles++;
    end
    $display("Timeout, the run did not finish within %0d cycles", limit);
    $display("Checked %0d words, %0d errors", words_seen, errors);
    $display("Regression failed");
    $finish;
  end

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    ccd_data         = '0;
    ccd_fval         = 1'b0;
    ccd_lval         = 1'b0;
    capture_start    = 1'b0;
    hue_mode         = 1'b0;
    hps_fpga_reset_n = 1'b0;
    errors           = 0;
    words_seen       = 0;
    armed_frames     = 0;
    load_table();
    limit = 200;
    for (int i = 0; i < num_frames; i++) begin
      limit += 2 * frame_cycles(frames[i]);
    end
    repeat (3) @(posedge ccd_pixel_clk);
    #drive_delay;
    hps_fpga_reset_n = 1'b1;
    step(1'b0, 1'b0, '0);
    // Idle outputs straight after reset
    assert (word_valid === 1'b0) else begin
      errors++;
      $display("FAIL word_valid: expected %h, got %h", 1'b0, word_valid);
    end
    assert (frame_count === '0) else begin
      errors++;
      $display("FAIL frame_count: expected %h, got %h", 32'h0, frame_count);
    end
    for (int i = 0; i < num_frames; i++) begin
      run_frame(frames[i]);
    end
    assert (expected_words.size() == 0) else begin
      errors++;
      $display("%0d expected words never appeared", expected_words.size());
    end
    $display("Checked %0d words, %0d errors", words_seen, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
capture_pkg.sv
pixel_pkg.sv
camera_capture.sv
bayer_demosaic.sv
hue_calc.sv
pixel_path_top.sv
tb_pixel_path.sv
